//--- verilog/display_timing_pkg.sv
// display timing constants
// scan rates for the multiplexed seven-segment driver, all counted in clocks of
// the single system clock
package display_timing_pkg;

	// clocks spent on one segment slot
	localparam int segment_period = 4;

	// prescaler width, at least one bit even for a one-clock slot
	localparam int prescale_width = (segment_period > 1) ? $clog2(segment_period) : 1;

	// segments scanned per digit
	localparam int number_of_segments = 7;

	// digits on the display
	localparam int number_of_digits = 4;

	// clocks per digit, every segment gets one slot
	localparam int digit_period = number_of_segments * segment_period;

	// clocks per full frame across all digits
	localparam int frame_period = number_of_digits * digit_period;

endpackage

//--- verilog/segment_pkg.sv
// segment encoding definitions
// pattern and index types plus the hex glyph table, active high with bit 0 as
// segment a through bit 6 as segment g
package segment_pkg;

	// one bit per segment, set means lit
	typedef logic [display_timing_pkg::number_of_segments-1:0] segment_pattern_t;

	// one-hot slot marker, same layout as a pattern
	typedef logic [display_timing_pkg::number_of_segments-1:0] segment_token_t;

	// which digit is being scanned
	typedef logic [$clog2(display_timing_pkg::number_of_digits)-1:0] digit_index_t;

	// one hex digit of the data word
	typedef logic [3:0] nybble_t;

	// hex shapes, bit order g f e d c b a
	localparam segment_pattern_t glyph_table [16] = '{
		7'b0111111, // 0
		7'b0000110, // 1
		7'b1011011, // 2
		7'b1001111, // 3
		7'b1100110, // 4
		7'b1101101, // 5
		7'b1111101, // 6
		7'b0000111, // 7
		7'b1111111, // 8
		7'b1101111, // 9
		7'b1110111, // A
		7'b1111100, // b
		7'b0111001, // C
		7'b1011110, // d
		7'b1111001, // E
		7'b1110001  // F
	};

endpackage

//--- verilog/scan_sequencer.sv
// scan sequencer
// steps a one-hot segment token through each digit in turn and marks the frame
// boundary where new data is captured
module scan_sequencer (
	input  logic                     clock,
	input  logic                     reset,
	output segment_pkg::segment_token_t segment_token,
	output segment_pkg::digit_index_t   digit_index,
	output logic                     frame_start
);

	localparam logic [display_timing_pkg::prescale_width-1:0] prescale_last =
		display_timing_pkg::prescale_width'(display_timing_pkg::segment_period - 1);

	localparam segment_pkg::digit_index_t digit_last =
		segment_pkg::digit_index_t'(display_timing_pkg::number_of_digits - 1);

	localparam segment_pkg::segment_token_t token_first =
		segment_pkg::segment_token_t'(1); // segment a

	localparam int seg_msb = display_timing_pkg::number_of_segments - 1;

	logic [display_timing_pkg::prescale_width-1:0] prescale_count;
	logic slot_end;     // last clock of the current segment slot
	logic digit_end;    // last clock of segment g
	logic frame_end;    // last clock of the last digit
	logic start_pending; // set by reset, forces a capture on the first clock

	assign slot_end = (prescale_count == prescale_last);
	assign digit_end = slot_end & segment_token[seg_msb];
	assign frame_end = digit_end & (digit_index == digit_last);

	// prescaler, one wrap per segment slot
	always_ff @(posedge clock) begin
		if (reset) begin
			prescale_count <= '0;
		end else if (slot_end) begin
			prescale_count <= '0;
		end else begin
			prescale_count <= prescale_count + 1'b1;
		end
	end

	// token ring, rotates toward segment g and back to a
	always_ff @(posedge clock) begin
		if (reset) begin
			segment_token <= token_first;
		end else if (slot_end) begin
			segment_token <= {segment_token[seg_msb-1:0], segment_token[seg_msb]};
		end
	end

	// digit counter advances when the token leaves segment g
	always_ff @(posedge clock) begin
		if (reset) begin
			digit_index <= '0;
		end else if (digit_end) begin
			if (digit_index == digit_last) begin
				digit_index <= '0;
			end else begin
				digit_index <= digit_index + 1'b1;
			end
		end
	end

	// holds high through reset and for the first clock after it
	always_ff @(posedge clock) begin
		if (reset) begin
			start_pending <= 1'b1;
		end else begin
			start_pending <= 1'b0;
		end
	end

	// encoder samples on this edge, so digit 0 starts with fresh glyphs
	assign frame_start = start_pending | frame_end;

endmodule

//--- verilog/glyph_encoder.sv
// glyph encoder
// latches the data word once per frame and holds the four decoded hex glyphs
// so the whole frame shows a single value
module glyph_encoder (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       frame_start,
	input  logic [15:0]                data,
	output segment_pkg::segment_pattern_t pattern_0,
	output segment_pkg::segment_pattern_t pattern_1,
	output segment_pkg::segment_pattern_t pattern_2,
	output segment_pkg::segment_pattern_t pattern_3
);

	localparam int digits = display_timing_pkg::number_of_digits;

	segment_pkg::nybble_t          nybble [digits];       // split data word
	segment_pkg::segment_pattern_t glyph [digits];        // decoded, not yet held
	segment_pkg::segment_pattern_t pattern_held [digits];

	// nybble 0 is the low four bits, drives the rightmost digit
	always_comb begin
		for (int i = 0; i < digits; i++) begin
			nybble[i] = data[4*i +: 4];
			glyph[i] = segment_pkg::glyph_table[nybble[i]];
		end
	end

	// capture on the frame boundary only, the data word is free to move
	// at any other time
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < digits; i++) begin
				pattern_held[i] <= '0; // blank
			end
		end else if (frame_start) begin
			for (int i = 0; i < digits; i++) begin
				pattern_held[i] <= glyph[i];
			end
		end
	end

	assign pattern_0 = pattern_held[0];
	assign pattern_1 = pattern_held[1];
	assign pattern_2 = pattern_held[2];
	assign pattern_3 = pattern_held[3];

endmodule

//--- verilog/drive_combiner.sv
// drive combiner
// picks the active digit's glyph, keeps only the segment under the token, and
// registers the anode and cathode pins
module drive_combiner (
	input  logic                                         clock,
	input  logic                                         reset,
	input  segment_pkg::segment_token_t                  segment_token,
	input  segment_pkg::digit_index_t                    digit_index,
	input  segment_pkg::segment_pattern_t                pattern_0,
	input  segment_pkg::segment_pattern_t                pattern_1,
	input  segment_pkg::segment_pattern_t                pattern_2,
	input  segment_pkg::segment_pattern_t                pattern_3,
	output logic [display_timing_pkg::number_of_digits-1:0]   anode,
	output logic [display_timing_pkg::number_of_segments-1:0] cathode
);

	segment_pkg::segment_pattern_t current_pattern; // glyph of the scanned digit
	segment_pkg::segment_pattern_t lit;             // at most one bit set
	logic [display_timing_pkg::number_of_digits-1:0] anode_next;

	// digit mux
	always_comb begin
		case (digit_index)
			2'd0: current_pattern = pattern_0;
			2'd1: current_pattern = pattern_1;
			2'd2: current_pattern = pattern_2;
			default: current_pattern = pattern_3;
		endcase
	end

	// only one segment can draw current at a time
	assign lit = current_pattern & segment_token;

	// one-hot digit enable
	always_comb begin
		anode_next = '0;
		anode_next[digit_index] = 1'b1;
	end

	// output stage, one clock behind the sequencer
	always_ff @(posedge clock) begin
		if (reset) begin
			anode <= '0;   // all digits off
			cathode <= '1; // all segments dark
		end else begin
			anode <= anode_next;
			cathode <= ~lit; // cathodes sink current, so active low
		end
	end

endmodule

//--- verilog/display_driver_top.sv
// four-digit seven-segment display driver
// shows a 16-bit value as hex, scanning one segment at a time
module display_driver_top (
	input  logic                                              clock,
	input  logic                                              reset,
	input  logic [15:0]                                       data,
	output logic [display_timing_pkg::number_of_digits-1:0]   anode,
	output logic [display_timing_pkg::number_of_segments-1:0] cathode
);

	segment_pkg::segment_token_t   segment_token;
	segment_pkg::digit_index_t     digit_index;
	logic                          frame_start;
	segment_pkg::segment_pattern_t pattern_0;
	segment_pkg::segment_pattern_t pattern_1;
	segment_pkg::segment_pattern_t pattern_2;
	segment_pkg::segment_pattern_t pattern_3;

	scan_sequencer i_scan_sequencer (
		.clock         (clock),
		.reset         (reset),
		.segment_token (segment_token),
		.digit_index   (digit_index),
		.frame_start   (frame_start)
	);

	// glyphs refresh only between frames
	glyph_encoder i_glyph_encoder (
		.clock       (clock),
		.reset       (reset),
		.frame_start (frame_start),
		.data        (data),
		.pattern_0   (pattern_0),
		.pattern_1   (pattern_1),
		.pattern_2   (pattern_2),
		.pattern_3   (pattern_3)
	);

	drive_combiner i_drive_combiner (
		.clock         (clock),
		.reset         (reset),
		.segment_token (segment_token),
		.digit_index   (digit_index),
		.pattern_0     (pattern_0),
		.pattern_1     (pattern_1),
		.pattern_2     (pattern_2),
		.pattern_3     (pattern_3),
		.anode         (anode),
		.cathode       (cathode)
	);

endmodule

//--- tb/display_driver_checks.svh
// display driver checks
// hex glyph reference and compare tasks for the display driver testbench
`ifndef DISPLAY_DRIVER_CHECKS_SVH
`define DISPLAY_DRIVER_CHECKS_SVH

// builds a pattern from segment letters, a is bit 0
function automatic segment_pkg::segment_pattern_t segments_from(input string letters);
	segment_pkg::segment_pattern_t result;
	result = '0;
	for (int i = 0; i < letters.len(); i++) begin
		result = result | (segment_pkg::segment_pattern_t'(1) << (letters[i] - "a"));
	end
	return result;
endfunction

// lit segments expected for one hex digit
function automatic segment_pkg::segment_pattern_t expected_glyph(input segment_pkg::nybble_t value);
	case (value)
		4'h0: return segments_from("abcdef");
		4'h1: return segments_from("bc");
		4'h2: return segments_from("abdeg");
		4'h3: return segments_from("abcdg");
		4'h4: return segments_from("bcfg");
		4'h5: return segments_from("acdfg");
		4'h6: return segments_from("acdefg");
		4'h7: return segments_from("abc");
		4'h8: return segments_from("abcdefg");
		4'h9: return segments_from("abcdfg");
		4'ha: return segments_from("abcefg");
		4'hb: return segments_from("cdefg"); // lower case b
		4'hc: return segments_from("adef");
		4'hd: return segments_from("bcdeg"); // lower case d
		4'he: return segments_from("adefg");
		default: return segments_from("aefg"); // F
	endcase
endfunction

task automatic check_pattern(input int digit, input segment_pkg::segment_pattern_t expected,
	input segment_pkg::segment_pattern_t actual);
	if (actual !== expected) begin
		$display("** Error: lit segments of digit %0d: expected %h, actual %h",
			digit, expected, actual);
		stop_with_failure("");
	end
endtask

task automatic check_anode(input logic [display_timing_pkg::number_of_digits-1:0] expected,
	input logic [display_timing_pkg::number_of_digits-1:0] actual);
	if (actual !== expected) begin
		$display("** Error: anode: expected %h, actual %h", expected, actual);
		stop_with_failure("");
	end
endtask

task automatic check_cathode(input logic [display_timing_pkg::number_of_segments-1:0] expected,
	input logic [display_timing_pkg::number_of_segments-1:0] actual);
	if (actual !== expected) begin
		$display("** Error: cathode: expected %h, actual %h", expected, actual);
		stop_with_failure("");
	end
endtask

`endif

//--- tb/display_driver_tb.sv
// display driver testbench
// drives hex values into the display driver and checks every scanned frame
module display_driver_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int frame_period = display_timing_pkg::frame_period;
	localparam int digit_period = display_timing_pkg::digit_period;
	localparam int segment_period = display_timing_pkg::segment_period;
	localparam int digits = display_timing_pkg::number_of_digits;
	localparam int reset_cycles = 10;
	localparam int frames_per_value = 3;
	localparam int fixed_values = 4;
	localparam int random_values = 20;
	localparam int burst_values = 1; // one frame of data changing every clock
	localparam int cycle_limit = (fixed_values + random_values + burst_values + 2)
		* frames_per_value * frame_period + reset_cycles;

	logic clock;
	logic reset;
	logic [15:0] data;
	logic [digits-1:0] anode;
	logic [display_timing_pkg::number_of_segments-1:0] cathode;

	integer seed;
	int cycle_count;
	int frames_checked;
	bit window_active;
	int sample_index; // clock within the current frame window
	logic [15:0] seen_now[$]; // data values seen in this window
	logic [15:0] seen_before[$]; // data values seen in the previous window
	segment_pkg::segment_pattern_t lit_union [digits];

	display_driver_top i_dut (
		.clock   (clock),
		.reset   (reset),
		.data    (data),
		.anode   (anode),
		.cathode (cathode)
	);

	task automatic stop_with_failure(input string reason);
		if (reason != "") begin
			$display("%s", reason);
		end
		$display("RESULT: FAIL");
		$fatal(1, "stopping at the first error");
	endtask

	`include "display_driver_checks.svh"

	function automatic segment_pkg::nybble_t nybble_of(input logic [15:0] value, input int digit);
		return segment_pkg::nybble_t'(value >> (4 * digit));
	endfunction

	// true when all four unions show this data value
	function automatic bit matches_value(input logic [15:0] value);
		for (int d = 0; d < digits; d++) begin
			if (lit_union[d] !== expected_glyph(nybble_of(value, d))) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// per clock, digit and slot follow from the position in the frame
	task automatic check_sample();
		int digit;
		int slot;
		segment_pkg::segment_pattern_t lit;
		segment_pkg::segment_pattern_t allowed;
		digit = sample_index / digit_period;
		slot = (sample_index % digit_period) / segment_period;
		check_anode(4'b0001 << digit, anode);
		lit = ~cathode;
		allowed = '0;
		foreach (seen_before[i]) begin
			allowed = allowed | expected_glyph(nybble_of(seen_before[i], digit));
		end
		allowed = allowed & (segment_pkg::segment_pattern_t'(1) << slot); // the slot's own segment
		check_pattern(digit, '0, lit & ~allowed); // nothing lit outside that segment
		lit_union[digit] = lit_union[digit] | lit;
	endtask

	// whole frame must come from a single value seen during the previous window
	task automatic check_frame();
		logic [15:0] shown;
		shown = seen_before[$];
		foreach (seen_before[i]) begin
			if (matches_value(seen_before[i])) begin
				shown = seen_before[i];
			end
		end
		for (int d = 0; d < digits; d++) begin
			check_pattern(d, expected_glyph(nybble_of(shown, d)), lit_union[d]);
			lit_union[d] = '0;
		end
		frames_checked++;
	endtask

	task automatic apply_value(input logic [15:0] value);
		int target;
		@(posedge clock);
		#1;
		data = value;
		target = frames_checked + frames_per_value;
		wait (frames_checked >= target);
	endtask

	task automatic change_every_clock();
		int target;
		@(posedge clock);
		#1;
		for (int i = 0; i < frame_period; i++) begin
			data = 16'($random(seed));
			@(posedge clock);
			#1;
		end
		target = frames_checked + frames_per_value - 1; // burst frame already done
		wait (frames_checked >= target);
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		stop_with_failure("simulation timed out");
	end

	// frame monitor, outputs are stable at the falling edge
	always @(negedge clock) begin
		if (reset === 1'b0) begin
			if (!window_active) begin
				if (anode === '0) begin
					check_cathode('1, cathode); // dark until the first slot
				end else begin
					check_anode(4'b0001, anode);
					window_active = 1'b1;
					sample_index = 0;
					for (int d = 0; d < digits; d++) begin
						lit_union[d] = '0;
					end
					seen_before = seen_now;
					seen_now.delete();
				end
			end
			seen_now.push_back(data);
			if (window_active) begin
				check_sample();
				if (sample_index == frame_period - 1) begin
					check_frame();
					seen_before = seen_now;
					seen_now.delete();
					sample_index = 0;
				end else begin
					sample_index++;
				end
			end
		end
	end

	initial begin
		seed = 32'hc27;
		window_active = 1'b0;
		frames_checked = 0;
		sample_index = 0;
		reset = 1'b1;
		data = 16'h0123; // captured by the first frame after reset
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
		wait (frames_checked >= frames_per_value);
		apply_value(16'h4567);
		apply_value(16'h89ab);
		apply_value(16'hcdef);
		repeat (random_values) begin
			apply_value(16'($random(seed)));
		end
		change_every_clock();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- all.f
+incdir+tb
verilog/display_timing_pkg.sv
verilog/segment_pkg.sv
verilog/scan_sequencer.sv
verilog/glyph_encoder.sv
verilog/drive_combiner.sv
verilog/display_driver_top.sv
tb/display_driver_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the display driver testbench with Verilator, runs it and checks the log

verilator --binary --timing -f all.f --top-module display_driver_tb -Mdir obj_dir \
	-o display_driver_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/display_driver_sim > sim.log 2>&1

grep -qx "RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
